// ==== cmp_pkg.sv ====
// comparator package with operand widths, pipeline latency and the stage bundle types
package cmp_pkg;

    ////////////////////
    // widths
    ////////////////////

    // one operand, also the width of the difference word
    localparam int OPERAND_WIDTH = 512;
    localparam int BYTE_WIDTH = 8;
    // 64 bytes per operand
    localparam int NUM_BYTES = OPERAND_WIDTH / BYTE_WIDTH;
    // second search level works on groups of eight bytes
    localparam int BYTES_PER_GROUP = 8;
    localparam int NUM_GROUPS = NUM_BYTES / BYTES_PER_GROUP;

    // capture, byte scan, group select, encode
    localparam int PIPE_LATENCY = 4;

    ////////////////////
    // vector types
    ////////////////////

    // operand or difference word, indexed by byte then by bit
    typedef logic [NUM_BYTES-1:0][BYTE_WIDTH-1:0] operand_t;

    // one flag per byte of the full word
    typedef logic [NUM_BYTES-1:0] byte_flags_t;

    // one flag per byte inside a single group
    typedef logic [BYTES_PER_GROUP-1:0] group_byte_flags_t;

    ////////////////////
    // stage bundles
    ////////////////////

    // top level input pair
    typedef struct packed {
        operand_t a;
        operand_t b;
    } operand_pair_t;

    // input side output
    // diff is a xor b, a is kept for the winner bits
    typedef struct packed {
        operand_t diff;
        operand_t a;
    } diff_word_t;

    // byte scan output
    typedef struct packed {
        // byte has at least one differing bit
        byte_flags_t nonzero;
        // a's bit at the top differing bit of the byte
        byte_flags_t a_wins;
    } byte_summary_t;

    // group select output, only the winning group survives
    typedef struct packed {
        logic              any_diff;
        group_byte_flags_t nonzero;
        group_byte_flags_t a_wins;
    } group_pick_t;

    ////////////////////
    // result word
    ////////////////////

    // named view of the one-hot code, gt sits in the msb
    typedef struct packed {
        logic gt;
        logic eq;
        logic lt;
    } cmp_flags_t;

    // gt 100, eq 010, lt 001; 000 only before the first result
    typedef union packed {
        logic [2:0] code;
        cmp_flags_t flags;
    } cmp_result_u;

endpackage

// ==== operand_capture.sv ====
// operand capture stage that registers operand a and the a xor b difference word
`timescale 1ns/1ps

module operand_capture (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  cmp_pkg::operand_pair_t operands,
    output logic                 capture_valid,
    output cmp_pkg::diff_word_t  captured
);
    import cmp_pkg::*;

    // difference word, a set bit marks a position where a and b disagree
    operand_t diff_c;

    always_comb begin
        diff_c = operands.a ^ operands.b;
    end

    ////////////////////
    // valid pipe
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            capture_valid <= 1'b0;
        end else begin
            capture_valid <= in_valid;
        end
    end

    ////////////////////
    // payload
    ////////////////////

    // a is carried along since the winner bits are read from it
    always_ff @(posedge clk) begin
        if (in_valid) begin
            captured.diff <= diff_c;
            captured.a    <= operands.a;
        end
    end

endmodule

// ==== byte_scan.sv ====
// byte scan stage that flags nonzero difference bytes and finds each byte's local winner bit
`timescale 1ns/1ps

module byte_scan (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  capture_valid,
    input  cmp_pkg::diff_word_t   captured,
    output logic                  scan_valid,
    output cmp_pkg::byte_summary_t summary
);
    import cmp_pkg::*;

    byte_flags_t nonzero_c;
    byte_flags_t a_wins_c;

    // and-or priority form
    // term k is a[k] when d[k] is the top set bit of the byte, else 0
    function automatic logic local_winner(input logic [BYTE_WIDTH-1:0] d,
                                          input logic [BYTE_WIDTH-1:0] av);
        logic [BYTE_WIDTH-1:0] terms;
        logic                  higher;
        higher = 1'b0;
        for (int k = BYTE_WIDTH - 1; k >= 0; k--) begin
            terms[k] = av[k] & d[k] & ~higher;
            // any set bit above masks every lower term
            higher   = higher | d[k];
        end
        return |terms;
    endfunction

    ////////////////////
    // per-byte flags
    ////////////////////

    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            nonzero_c[i] = |captured.diff[i];
            // only meaningful when the byte is nonzero, 0 otherwise
            a_wins_c[i]  = local_winner(captured.diff[i], captured.a[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_valid <= 1'b0;
        end else begin
            scan_valid <= capture_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_valid) begin
            summary.nonzero <= nonzero_c;
            summary.a_wins  <= a_wins_c;
        end
    end

endmodule

// ==== group_select.sv ====
// group select stage that picks the highest group holding a difference and keeps its byte flags
`timescale 1ns/1ps

module group_select (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   scan_valid,
    input  cmp_pkg::byte_summary_t summary,
    output logic                   group_valid,
    output cmp_pkg::group_pick_t   pick
);
    import cmp_pkg::*;

    // one flag per group of eight bytes
    logic [NUM_GROUPS-1:0] group_flags;
    logic                  any_diff_c;
    group_byte_flags_t     nonzero_c;
    group_byte_flags_t     a_wins_c;

    ////////////////////
    // group flags
    ////////////////////

    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            group_flags[g] = |summary.nonzero[g*BYTES_PER_GROUP +: BYTES_PER_GROUP];
        end
    end

    // no group flag means the operands are equal
    assign any_diff_c = |group_flags;

    ////////////////////
    // group mux
    ////////////////////

    // scan upward so the highest flagged group is the last one written
    // with no flag at all group 0 is passed on, encode ignores it then
    always_comb begin
        nonzero_c = summary.nonzero[0 +: BYTES_PER_GROUP];
        a_wins_c  = summary.a_wins[0 +: BYTES_PER_GROUP];
        for (int g = 1; g < NUM_GROUPS; g++) begin
            if (group_flags[g]) begin
                nonzero_c = summary.nonzero[g*BYTES_PER_GROUP +: BYTES_PER_GROUP];
                a_wins_c  = summary.a_wins[g*BYTES_PER_GROUP +: BYTES_PER_GROUP];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            group_valid <= 1'b0;
        end else begin
            group_valid <= scan_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (scan_valid) begin
            pick.any_diff <= any_diff_c;
            pick.nonzero  <= nonzero_c;
            pick.a_wins   <= a_wins_c;
        end
    end

endmodule

// ==== result_encode.sv ====
// result encode stage that picks the top differing byte of the group and registers the result
`timescale 1ns/1ps

module result_encode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 group_valid,
    input  cmp_pkg::group_pick_t pick,
    output logic                 result_valid,
    output cmp_pkg::cmp_result_u result
);
    import cmp_pkg::*;

    // a's bit at the highest differing bit of the whole word
    logic        winner;
    cmp_result_u result_c;

    ////////////////////
    // byte pick
    ////////////////////

    // highest nonzero byte wins, byte 0 by default
    always_comb begin
        winner = pick.a_wins[0];
        for (int i = 1; i < BYTES_PER_GROUP; i++) begin
            if (pick.nonzero[i]) begin
                winner = pick.a_wins[i];
            end
        end
    end

    // encode through the named flags, the code view is what leaves the block
    always_comb begin
        result_c.flags.gt = pick.any_diff & winner;
        result_c.flags.eq = ~pick.any_diff;
        result_c.flags.lt = pick.any_diff & ~winner;
    end

    ////////////////////
    // output regs
    ////////////////////

    // result holds between pulses, 000 until the first one
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result.code  <= 3'b000;
        end else begin
            result_valid <= group_valid;
            if (group_valid) begin
                result <= result_c;
            end
        end
    end

endmodule

// ==== comparator_512bit.sv ====
// pipelined 512-bit unsigned magnitude comparator reporting a greater, equal or a less
`timescale 1ns/1ps

module comparator_512bit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  cmp_pkg::operand_pair_t operands,
    output logic                   result_valid,
    output cmp_pkg::cmp_result_u   result
);
    import cmp_pkg::*;

    // stage to stage links, one valid bit beside each bundle
    logic          capture_valid;
    diff_word_t    captured;
    logic          scan_valid;
    byte_summary_t summary;
    logic          group_valid;
    group_pick_t   pick;

    ////////////////////
    // stage 1, a xor b
    ////////////////////

    operand_capture i_operand_capture (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .operands      (operands),
        .capture_valid (capture_valid),
        .captured      (captured)
    );

    // stage 2, per-byte flags
    byte_scan i_byte_scan (
        .clk           (clk),
        .reset         (reset),
        .capture_valid (capture_valid),
        .captured      (captured),
        .scan_valid    (scan_valid),
        .summary       (summary)
    );

    // stage 3, highest group
    group_select i_group_select (
        .clk         (clk),
        .reset       (reset),
        .scan_valid  (scan_valid),
        .summary     (summary),
        .group_valid (group_valid),
        .pick        (pick)
    );

    ////////////////////
    // stage 4, encode
    ////////////////////

    result_encode i_result_encode (
        .clk          (clk),
        .reset        (reset),
        .group_valid  (group_valid),
        .pick         (pick),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== comparator_512bit_properties.sv ====
// pipeline timing and result encoding properties bound to the comparator top level
`timescale 1ns/1ps

module comparator_512bit_properties (
    input logic                 clk,
    input logic                 reset,
    input logic                 in_valid,
    input logic                 result_valid,
    input cmp_pkg::cmp_result_u result
);
    import cmp_pkg::*;

    // counts failed assertions, read by the testbench
    int failure_count = 0;

    ////////////////////
    // valid timing
    ////////////////////

    // every result pulse matches an input exactly PIPE_LATENCY cycles back
    assert property (@(posedge clk) disable iff (reset)
                     result_valid == $past(in_valid, PIPE_LATENCY))
        else begin
            failure_count++;
            $error("result_valid does not follow in_valid by the pipeline latency");
        end

    // one-hot code on every result
    assert property (@(posedge clk) disable iff (reset)
                     result_valid |-> $onehot(result.code))
        else begin
            failure_count++;
            $error("result code is not one-hot while result_valid is high");
        end

    // quiet during reset and while the emptied pipe refills
    assert property (@(posedge clk) reset |=> !result_valid [*PIPE_LATENCY])
        else begin
            failure_count++;
            $error("result_valid high during reset or too soon after it");
        end

endmodule

bind comparator_512bit comparator_512bit_properties i_properties (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .result_valid (result_valid),
    .result       (result)
);

// ==== tb_comparator_512bit.sv ====
// testbench for the pipelined 512-bit comparator with a native-compare reference model
`timescale 1ns/1ps

module tb_comparator_512bit;
    import cmp_pkg::*;

    // about 1020 input cycles plus reset, idle and drain, roughly 2x margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic          clk;
    logic          reset;
    logic          in_valid;
    operand_pair_t operands;
    logic          result_valid;
    cmp_result_u   result;

    logic [63:0] rng_state;
    logic [2:0]  expected_q[$];
    int          cycle_count;

    comparator_512bit i_comparator_512bit (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .operands     (operands),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [63:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic logic [OPERAND_WIDTH-1:0] random_word();
        logic [OPERAND_WIDTH-1:0] w;
        for (int j = 0; j < OPERAND_WIDTH / 64; j++) begin
            w[j*64 +: 64] = next_random();
        end
        return w;
    endfunction

    // reference uses the native unsigned compare of the full words
    function automatic logic [2:0] expected_code(input logic [OPERAND_WIDTH-1:0] a,
                                                 input logic [OPERAND_WIDTH-1:0] b);
        if (a > b) begin
            return 3'b100;
        end else if (a == b) begin
            return 3'b010;
        end else begin
            return 3'b001;
        end
    endfunction

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    // in_valid stays high until release_input, so calls in a row are back to back
    task automatic apply_pair(input logic [OPERAND_WIDTH-1:0] a,
                              input logic [OPERAND_WIDTH-1:0] b);
        @(negedge clk);
        operands.a = a;
        operands.b = b;
        in_valid   = 1'b1;
        expected_q.push_back(expected_code(a, b));
    endtask

    task automatic release_input();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // nothing applied yet, result must sit at its reset code
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            assert (result.code == 3'b000) else begin
                $display("MISMATCH time=%0t signal=result expected=000 actual=%03b",
                         $time, result.code);
                fail_run();
            end
        end
    endtask

    ////////////////////
    // checking
    ////////////////////

    always @(posedge clk) begin
        logic [2:0] expected;
        assert (i_comparator_512bit.i_properties.failure_count == 0) else begin
            $display("a pipeline property failed at time %0t", $time);
            fail_run();
        end
        if (!reset && result_valid) begin
            assert (expected_q.size() != 0) else begin
                $display("unexpected result at time %0t with no input pending", $time);
                fail_run();
            end
            if (expected_q.size() != 0) begin
                expected = expected_q.pop_front();
                assert (result.code === expected) else begin
                    $display("MISMATCH time=%0t signal=result expected=%03b actual=%03b",
                             $time, expected, result.code);
                    fail_run();
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycle_count, expected_q.size());
            fail_run();
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        logic [OPERAND_WIDTH-1:0] a;
        logic [OPERAND_WIDTH-1:0] b;
        logic [OPERAND_WIDTH-1:0] upper_mask;
        rng_state   = 64'd78971;
        cycle_count = 0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        operands    = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_idle(8);

        // equal operands
        apply_pair('0, '0);
        apply_pair('1, '1);
        repeat (20) begin
            a = random_word();
            apply_pair(a, a);
        end
        release_input();

        // one flipped bit per position, covers every byte and group
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            a = random_word();
            b = a;
            b[i] = ~b[i];
            apply_pair(a, b);
        end
        release_input();

        // upper part shared, bytes k down to 0 redrawn in b
        for (int k = 0; k < NUM_BYTES; k++) begin
            upper_mask = {OPERAND_WIDTH{1'b1}} << ((k + 1) * BYTE_WIDTH);
            repeat (4) begin
                a = random_word();
                b = random_word();
                b = (a & upper_mask) | (b & ~upper_mask);
                apply_pair(a, b);
            end
        end
        // differences on both sides of each group boundary
        for (int g = 1; g < NUM_GROUPS; g++) begin
            repeat (4) begin
                a = random_word();
                b = a;
                b[g*BYTES_PER_GROUP*BYTE_WIDTH +: BYTE_WIDTH] = BYTE_WIDTH'(next_random());
                b[(g*BYTES_PER_GROUP-1)*BYTE_WIDTH +: BYTE_WIDTH] = BYTE_WIDTH'(next_random());
                apply_pair(a, b);
            end
        end
        release_input();

        // back to back random pairs
        repeat (200) begin
            apply_pair(random_word(), random_word());
        end
        release_input();

        while (expected_q.size() != 0) @(posedge clk);
        // a few more cycles so a stray extra result is caught
        repeat (PIPE_LATENCY + 2) @(posedge clk);
        if (i_comparator_512bit.i_properties.failure_count != 0) begin
            $display("a pipeline property failed during the run");
            fail_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== compile.f ====
cmp_pkg.sv
operand_capture.sv
byte_scan.sv
group_select.sv
result_encode.sv
comparator_512bit.sv
comparator_512bit_properties.sv
tb_comparator_512bit.sv
